// File: design/mem_pkg.sv
package mem_pkg;

    // memory side widths.
    localparam int ADDR_BITS = 32;
    localparam int LINE_BITS = 256;
    localparam int BEAT_BITS = 64;

    // beats in one line burst.
    localparam int LINE_BEATS = LINE_BITS / BEAT_BITS;

    localparam int BEAT_IDX_BITS = $clog2(LINE_BEATS);

    // byte address of a line.
    typedef logic [ADDR_BITS-1:0] addr_t;

    // whole cache line.
    typedef logic [LINE_BITS-1:0] line_t;

    // one memory bus beat.
    typedef logic [BEAT_BITS-1:0] beat_t;

    // position of a beat within its burst.
    typedef logic [BEAT_IDX_BITS-1:0] beat_idx_t;

endpackage : mem_pkg

// File: design/arb_pkg.sv
package arb_pkg;

    // arbiter grant states.
    typedef enum logic [1:0] {
        idle,
        instruction,
        data
    } arb_state_e;

    // how contending requests are resolved.
    typedef enum logic {
        prio_data_first = 1'b0,
        prio_alternate  = 1'b1
    } prio_mode_e;

    // configuration register map.
    typedef enum logic [1:0] {
        reg_mode   = 2'd0,
        reg_icount = 2'd1,
        reg_dcount = 2'd2
    } cfg_reg_e;

endpackage : arb_pkg

// File: design/arb_config.sv
`timescale 1ns/1ps

module arb_config
    import arb_pkg::*;
#(
    parameter int COUNT_BITS = 16
)
(
    input  logic        clk,
    input  logic        rst,

    input  logic        cfg_we,
    input  cfg_reg_e    cfg_addr,
    input  logic [31:0] cfg_wdata,
    output logic [31:0] cfg_rdata,

    input  logic        grant_inst,
    input  logic        grant_data,
    output prio_mode_e  prio_mode
);

    logic [COUNT_BITS-1:0] icount;
    logic [COUNT_BITS-1:0] dcount;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            prio_mode <= prio_data_first;
            icount    <= '0;
            dcount    <= '0;
        end
        else
        begin
            if (cfg_we && cfg_addr == reg_mode)
                prio_mode <= prio_mode_e'(cfg_wdata[0]);

            if (cfg_we && cfg_addr == reg_icount)
                icount <= '0; // clear wins over a grant.
            else if (grant_inst && icount != '1)
                icount <= icount + 1'b1;

            if (cfg_we && cfg_addr == reg_dcount)
                dcount <= '0;
            else if (grant_data && dcount != '1)
                dcount <= dcount + 1'b1; // saturates at all ones.
        end
    end

    always_comb
    begin
        unique case (cfg_addr)
            reg_mode:   cfg_rdata = {31'b0, prio_mode};
            reg_icount: cfg_rdata = 32'(icount); // zero extended.
            reg_dcount: cfg_rdata = 32'(dcount);
            default:    cfg_rdata = 32'b0;
        endcase
    end

endmodule : arb_config

// File: design/arbiter.sv
`timescale 1ns/1ps

module arbiter
    import mem_pkg::*;
    import arb_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       icache_read,
    input  addr_t      icache_addr,
    output line_t      icache_data,
    output logic       icache_resp,

    input  logic       dcache_read,
    input  logic       dcache_write,
    input  addr_t      dcache_addr,
    input  line_t      dcache_wdata,
    output line_t      dcache_rdata,
    output logic       dcache_resp,

    input  prio_mode_e prio_mode,
    output logic       grant_inst,
    output logic       grant_data,

    input  logic       arbiter_resp,
    input  line_t      arb_mem_rdata,
    output addr_t      arb_mem_address,
    output logic       arb_mem_read,
    output logic       arb_mem_write,
    output line_t      arb_mem_wdata
);

    arb_state_e state;
    arb_state_e next_state;
    logic       last_data; // last grant went to the data cache.
    logic       ireq;
    logic       dreq;

    assign ireq = icache_read;
    assign dreq = dcache_read | dcache_write;

    always_comb
    begin
        next_state = state;
        unique case (state)
            idle:
            begin
                if (dreq && ireq)
                begin
                    // contention resolved by the mode.
                    if (prio_mode == prio_data_first || !last_data)
                        next_state = data;
                    else
                        next_state = instruction;
                end
                else if (dreq)
                    next_state = data;
                else if (ireq)
                    next_state = instruction;
            end
            instruction:
            begin
                if (arbiter_resp)
                    next_state = idle;
            end
            data:
            begin
                if (arbiter_resp)
                    next_state = idle;
            end
            default: next_state = idle;
        endcase
    end

    assign grant_inst = (state == idle) && (next_state == instruction); // one pulse per grant.
    assign grant_data = (state == idle) && (next_state == data);

    always_comb
    begin
        icache_data     = '0;
        icache_resp     = 1'b0;
        dcache_rdata    = '0;
        dcache_resp     = 1'b0;
        arb_mem_address = '0;
        arb_mem_read    = 1'b0;
        arb_mem_write   = 1'b0;
        arb_mem_wdata   = '0;
        unique case (state)
            instruction:
            begin
                arb_mem_address = icache_addr;
                arb_mem_read    = icache_read;
                icache_data     = arb_mem_rdata;
                icache_resp     = arbiter_resp;
            end
            data:
            begin
                arb_mem_address = dcache_addr;
                arb_mem_read    = dcache_read;  // read and write pass separately.
                arb_mem_write   = dcache_write;
                arb_mem_wdata   = dcache_wdata;
                dcache_rdata    = arb_mem_rdata;
                dcache_resp     = arbiter_resp;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= idle;
            last_data <= 1'b0; // starts as instruction.
        end
        else
        begin
            state <= next_state;
            if (grant_data)
                last_data <= 1'b1;
            else if (grant_inst)
                last_data <= 1'b0;
        end
    end

endmodule : arbiter

// File: design/cacheline_adapter.sv
`timescale 1ns/1ps

module cacheline_adapter
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  arb_mem_read,
    input  logic  arb_mem_write,
    input  addr_t arb_mem_address,
    input  line_t arb_mem_wdata,
    output line_t arb_mem_rdata,
    output logic  arbiter_resp,

    output logic  pmem_read,
    output logic  pmem_write,
    output addr_t pmem_address,
    output beat_t pmem_wdata,
    input  logic  pmem_resp,
    input  beat_t pmem_rdata
);

    typedef enum logic [1:0] {
        idle,
        burst,
        done
    } adapter_state_e;

    adapter_state_e state;
    adapter_state_e next_state;
    beat_idx_t      beat_idx;
    logic           is_write;   // burst direction.
    logic           last_beat;
    addr_t          addr_q;
    line_t          wline_q;    // write line, shifted out low beat first.
    line_t          rline_q;    // read line, filled from the top.

    assign last_beat = (beat_idx == beat_idx_t'(LINE_BEATS - 1));

    always_comb
    begin
        next_state = state;
        unique case (state)
            idle:
            begin
                if (arb_mem_read || arb_mem_write)
                    next_state = burst;
            end
            burst:
            begin
                if (pmem_resp && last_beat)
                    next_state = done;
            end
            done:    next_state = idle;
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= idle;
            beat_idx <= '0;
            is_write <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (state == idle && next_state == burst)
            begin
                beat_idx <= '0;
                is_write <= arb_mem_write;
            end
            else if (state == burst && pmem_resp)
                beat_idx <= beat_idx + 1'b1; // wraps to zero after the last beat.
        end
    end

    // payload registers.
    always_ff @(posedge clk)
    begin
        if (state == idle && (arb_mem_read || arb_mem_write))
        begin
            addr_q  <= arb_mem_address;
            wline_q <= arb_mem_wdata;
        end
        else if (state == burst && pmem_resp)
        begin
            wline_q <= wline_q >> BEAT_BITS;
            rline_q <= {pmem_rdata, rline_q[LINE_BITS-1:BEAT_BITS]};
        end
    end

    assign pmem_read     = (state == burst) && !is_write;
    assign pmem_write    = (state == burst) && is_write;
    assign pmem_address  = addr_q;
    assign pmem_wdata    = wline_q[BEAT_BITS-1:0]; // current beat sits at the bottom.
    assign arbiter_resp  = (state == done);
    assign arb_mem_rdata = rline_q;

endmodule : cacheline_adapter

// File: design/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem
    import mem_pkg::*;
    import arb_pkg::*;
#(
    parameter int COUNT_BITS = 16
)
(
    input  logic        clk,
    input  logic        rst,

    input  logic        icache_read,
    input  addr_t       icache_addr,
    output line_t       icache_data,
    output logic        icache_resp,

    input  logic        dcache_read,
    input  logic        dcache_write,
    input  addr_t       dcache_addr,
    input  line_t       dcache_wdata,
    output line_t       dcache_rdata,
    output logic        dcache_resp,

    input  logic        cfg_we,
    input  cfg_reg_e    cfg_addr,
    input  logic [31:0] cfg_wdata,
    output logic [31:0] cfg_rdata,

    output logic        pmem_read,
    output logic        pmem_write,
    output addr_t       pmem_address,
    output beat_t       pmem_wdata,
    input  logic        pmem_resp,
    input  beat_t       pmem_rdata
);

    prio_mode_e prio_mode;
    logic       grant_inst;
    logic       grant_data;
    logic       arbiter_resp;
    line_t      arb_mem_rdata;
    addr_t      arb_mem_address;
    logic       arb_mem_read;
    logic       arb_mem_write;
    line_t      arb_mem_wdata;

    arb_config #(
        .COUNT_BITS (COUNT_BITS)
    ) u_config (
        .clk        (clk),
        .rst        (rst),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .grant_inst (grant_inst),
        .grant_data (grant_data),
        .prio_mode  (prio_mode)
    );

    arbiter u_arbiter (
        .clk             (clk),
        .rst             (rst),
        .icache_read     (icache_read),
        .icache_addr     (icache_addr),
        .icache_data     (icache_data),
        .icache_resp     (icache_resp),
        .dcache_read     (dcache_read),
        .dcache_write    (dcache_write),
        .dcache_addr     (dcache_addr),
        .dcache_wdata    (dcache_wdata),
        .dcache_rdata    (dcache_rdata),
        .dcache_resp     (dcache_resp),
        .prio_mode       (prio_mode),
        .grant_inst      (grant_inst),
        .grant_data      (grant_data),
        .arbiter_resp    (arbiter_resp),
        .arb_mem_rdata   (arb_mem_rdata),
        .arb_mem_address (arb_mem_address),
        .arb_mem_read    (arb_mem_read),
        .arb_mem_write   (arb_mem_write),
        .arb_mem_wdata   (arb_mem_wdata)
    );

    cacheline_adapter u_adapter (
        .clk             (clk),
        .rst             (rst),
        .arb_mem_read    (arb_mem_read),
        .arb_mem_write   (arb_mem_write),
        .arb_mem_address (arb_mem_address),
        .arb_mem_wdata   (arb_mem_wdata),
        .arb_mem_rdata   (arb_mem_rdata),
        .arbiter_resp    (arbiter_resp),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .pmem_address    (pmem_address),
        .pmem_wdata      (pmem_wdata),
        .pmem_resp       (pmem_resp),
        .pmem_rdata      (pmem_rdata)
    );

endmodule : mem_subsystem

// File: verification/burst_mem_model.sv
`timescale 1ns/1ps

module burst_mem_model
    import mem_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h1
)
(
    input  logic  clk,
    input  logic  rst,
    input  logic  pmem_read,
    input  logic  pmem_write,
    input  addr_t pmem_address,
    input  beat_t pmem_wdata,
    output logic  pmem_resp,
    output beat_t pmem_rdata
);

    beat_t                                mem [logic [ADDR_BITS+BEAT_IDX_BITS-1:0]];
    logic [ADDR_BITS+BEAT_IDX_BITS-1:0]   key;
    logic [31:0]                          lfsr;
    beat_idx_t                            beat;
    int                                   gap_left; // idle cycles before the next beat.

    // galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    task automatic draw_gap();
        int g;
        g = 0;
        for (int i = 0; i < 2; i++)
        begin
            lfsr = lfsr_step(lfsr);
            g    = (g << 1) | int'(lfsr[0]); // one step per bit.
        end
        gap_left = g;
    endtask

    initial
    begin
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
    end

    always @(negedge clk)
    begin
        if (rst || !(pmem_read || pmem_write))
        begin
            if (rst)
            begin
                lfsr = SEED;
                draw_gap();
            end
            beat      = '0;
            pmem_resp = 1'b0;
        end
        else if (gap_left > 0)
        begin
            gap_left  = gap_left - 1;
            pmem_resp = 1'b0;
        end
        else
        begin
            key = {pmem_address, beat};
            if (pmem_write)
                mem[key] = pmem_wdata;
            else if (mem.exists(key))
                pmem_rdata = mem[key];
            else
                pmem_rdata = beat_t'(pmem_address) + beat_t'(beat); // unwritten fill.
            pmem_resp = 1'b1;
            beat      = beat + 1'b1;
            draw_gap();
        end
    end

endmodule : burst_mem_model

// File: verification/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem
    import mem_pkg::*;
    import arb_pkg::*;
();

    localparam int          NUM_ROWS       = 17;
    localparam int          TIMEOUT_CYCLES = 200 * NUM_ROWS;
    localparam int          MIN_LATENCY    = 7; // counts the request and resp cycles.
    localparam logic [31:0] LFSR_SEED      = 32'h7145e9a6;

    typedef enum logic [2:0] {
        k_ifetch,
        k_dread,
        k_dwrite,
        k_both,
        k_cfg
    } kind_e;

    typedef struct packed {
        kind_e kind;
        addr_t addr;     // line address or register for cfg rows.
        line_t line;     // write line or register data for cfg rows.
        logic  win_data; // data cache answers first on a both-read row.
    } row_t;

    localparam line_t LINE_A = {64'h0a0a_0000_0000_0003, 64'h0a0a_0000_0000_0002,
                                64'h0a0a_0000_0000_0001, 64'h0a0a_0000_0000_0000};
    localparam line_t LINE_B = {64'hb0b0_1234_5678_9abc, 64'hb0b0_0000_ffff_0000,
                                64'hb0b0_8765_4321_0fed, 64'hb0b0_5555_aaaa_5555};

    logic        clk;
    logic        rst;
    logic        icache_read;
    addr_t       icache_addr;
    line_t       icache_data;
    logic        icache_resp;
    logic        dcache_read;
    logic        dcache_write;
    addr_t       dcache_addr;
    line_t       dcache_wdata;
    line_t       dcache_rdata;
    logic        dcache_resp;
    logic        cfg_we;
    cfg_reg_e    cfg_addr;
    logic [31:0] cfg_wdata;
    logic [31:0] cfg_rdata;
    logic        pmem_read;
    logic        pmem_write;
    addr_t       pmem_address;
    beat_t       pmem_wdata;
    logic        pmem_resp;
    beat_t       pmem_rdata;

    row_t  rows [NUM_ROWS];
    line_t shadow [addr_t]; // lines written by the data cache.
    int    cycle_count = 0;
    int    exp_icount;
    int    exp_dcount;

    mem_subsystem #(
        .COUNT_BITS (16)
    ) u_dut (
        .clk          (clk),
        .rst          (rst),
        .icache_read  (icache_read),
        .icache_addr  (icache_addr),
        .icache_data  (icache_data),
        .icache_resp  (icache_resp),
        .dcache_read  (dcache_read),
        .dcache_write (dcache_write),
        .dcache_addr  (dcache_addr),
        .dcache_wdata (dcache_wdata),
        .dcache_rdata (dcache_rdata),
        .dcache_resp  (dcache_resp),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_resp    (pmem_resp),
        .pmem_rdata   (pmem_rdata)
    );

    burst_mem_model #(
        .SEED (LFSR_SEED)
    ) u_mem (
        .clk          (clk),
        .rst          (rst),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_resp    (pmem_resp),
        .pmem_rdata   (pmem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped.");
    endtask

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run("timeout, the table did not finish within the cycle limit.");
    end

    function automatic beat_t expected_beat(input addr_t addr, input int b);
        line_t l;
        if (shadow.exists(addr))
        begin
            l = shadow[addr];
            return l[b*BEAT_BITS +: BEAT_BITS];
        end
        return beat_t'(addr) + beat_t'(b); // fill rule of the memory.
    endfunction

    task automatic check_line(input line_t got, input addr_t addr, input string who);
        beat_t exp;
        for (int b = 0; b < LINE_BEATS; b++)
        begin
            exp = expected_beat(addr, b);
            assert (got[b*BEAT_BITS +: BEAT_BITS] == exp)
            else abort_run($sformatf("Mismatch at %0t: %s line %h beat %0d is %h, expected %h",
                                     $time, who, addr, b, got[b*BEAT_BITS +: BEAT_BITS], exp));
        end
    endtask

    task automatic check_cfg(input cfg_reg_e reg_sel, input int expected, input string what);
        @(negedge clk);
        cfg_addr = reg_sel;
        @(negedge clk);
        assert (cfg_rdata == 32'(expected))
        else abort_run($sformatf("Mismatch at %0t: %s reads %0d, expected %0d",
                                 $time, what, cfg_rdata, expected));
    endtask

    task automatic write_cfg(input cfg_reg_e reg_sel, input logic [31:0] value);
        @(negedge clk);
        cfg_we    = 1'b1; // single-cycle strobe.
        cfg_addr  = reg_sel;
        cfg_wdata = value;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic run_cfg_row(input row_t r);
        cfg_reg_e sel;
        sel = cfg_reg_e'(r.addr[1:0]);
        check_cfg(reg_icount, exp_icount, "instruction grant count");
        check_cfg(reg_dcount, exp_dcount, "data grant count");
        write_cfg(sel, r.line[31:0]);
        if (sel == reg_mode)
            check_cfg(reg_mode, int'(r.line[0]), "priority mode");
        else
        begin
            if (sel == reg_icount)
                exp_icount = 0;
            else
                exp_dcount = 0;
            check_cfg(sel, 0, "cleared grant count");
        end
    endtask

    task automatic run_cache_row(input row_t r);
        logic seen_first;
        logic first_data;
        int   held;
        seen_first = 1'b0;
        first_data = 1'b0;
        held       = 1;
        if (r.kind == k_ifetch || r.kind == k_both)
            exp_icount = exp_icount + 1;
        if (r.kind != k_ifetch)
            exp_dcount = exp_dcount + 1;
        @(negedge clk);
        icache_read  = (r.kind == k_ifetch) || (r.kind == k_both);
        icache_addr  = icache_read ? r.addr : ~r.addr; // idle port points at another line.
        dcache_read  = (r.kind == k_dread) || (r.kind == k_both);
        dcache_write = (r.kind == k_dwrite);
        dcache_addr  = (r.kind == k_ifetch) ? ~r.addr : r.addr;
        dcache_wdata = r.line;
        while (icache_read || dcache_read || dcache_write)
        begin
            @(negedge clk);
            held = held + 1;
            assert (!(icache_resp && !icache_read))
            else abort_run("instruction cache got a response it did not request.");
            assert (!(dcache_resp && !(dcache_read || dcache_write)))
            else abort_run("data cache got a response it did not request.");
            if (icache_resp)
            begin
                assert (held >= MIN_LATENCY)
                else abort_run($sformatf("Mismatch at %0t: instruction response after %0d cycles",
                                         $time, held));
                check_line(icache_data, r.addr, "instruction");
                first_data  = seen_first ? first_data : 1'b0;
                seen_first  = 1'b1;
                icache_read = 1'b0; // low in the cycle after resp.
            end
            if (dcache_resp)
            begin
                assert (held >= MIN_LATENCY)
                else abort_run($sformatf("Mismatch at %0t: data response after %0d cycles",
                                         $time, held));
                if (dcache_read)
                    check_line(dcache_rdata, r.addr, "data");
                else
                    shadow[r.addr] = r.line;
                first_data   = seen_first ? first_data : 1'b1;
                seen_first   = 1'b1;
                dcache_read  = 1'b0;
                dcache_write = 1'b0;
            end
        end
        if (r.kind == k_both)
        begin
            assert (first_data == r.win_data)
            else abort_run($sformatf("Mismatch at %0t: both-read at %h, data first %0b, expected %0b",
                                     $time, r.addr, first_data, r.win_data));
        end
    endtask

    initial
    begin
        rst          = 1'b1;
        icache_read  = 1'b0;
        icache_addr  = '0;
        dcache_read  = 1'b0;
        dcache_write = 1'b0;
        dcache_addr  = '0;
        dcache_wdata = '0;
        cfg_we       = 1'b0;
        cfg_addr     = reg_mode;
        cfg_wdata    = '0;
        exp_icount   = 0;
        exp_dcount   = 0;
        rows = '{
            '{k_ifetch, 32'h0000_1000, '0, 1'b0},
            '{k_dread,  32'h0000_2000, '0, 1'b0},
            '{k_dwrite, 32'h0000_2000, LINE_A, 1'b0},
            '{k_dread,  32'h0000_2000, '0, 1'b0},
            '{k_ifetch, 32'h0000_2000, '0, 1'b0},
            '{k_both,   32'h0000_3000, '0, 1'b1},       // data-first mode.
            '{k_cfg,    addr_t'(reg_icount), '0, 1'b0},
            '{k_cfg,    addr_t'(reg_mode), line_t'(1), 1'b0},
            '{k_both,   32'h0000_4000, '0, 1'b1},       // last grant was instruction.
            '{k_dread,  32'h0000_2000, '0, 1'b0},
            '{k_both,   32'h0000_5000, '0, 1'b0},
            '{k_ifetch, 32'h0000_1000, '0, 1'b0},
            '{k_both,   32'h0000_6000, '0, 1'b1},
            '{k_dwrite, 32'h0000_6000, LINE_B, 1'b0},
            '{k_both,   32'h0000_6000, '0, 1'b0},
            '{k_cfg,    addr_t'(reg_dcount), '0, 1'b0},
            '{k_cfg,    addr_t'(reg_icount), '0, 1'b0}
        };
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (!icache_resp && !dcache_resp && !pmem_read && !pmem_write)
        else abort_run("a response or memory request was active right after reset.");
        check_cfg(reg_mode, 0, "priority mode after reset");
        check_cfg(reg_icount, 0, "instruction grant count after reset");
        check_cfg(reg_dcount, 0, "data grant count after reset");
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            if (rows[i].kind == k_cfg)
                run_cfg_row(rows[i]);
            else
                run_cache_row(rows[i]);
        end
        check_cfg(reg_icount, exp_icount, "final instruction grant count");
        check_cfg(reg_dcount, exp_dcount, "final data grant count");
        $display(">>> PASS");
        $finish;
    end

endmodule : tb_mem_subsystem

// File: verilog.f
design/mem_pkg.sv
design/arb_pkg.sv
design/arb_config.sv
design/arbiter.sv
design/cacheline_adapter.sv
design/mem_subsystem.sv
verification/burst_mem_model.sv
verification/tb_mem_subsystem.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_mem_subsystem \
        --Mdir obj_dir -o sim_tb -f verilog.f; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
